// ==== common/MemBusPkg.sv ====
/* Bus command word, client request record and the serial port
   constants used by the memory model and the controller */

`default_nettype none

package MemBusPkg;

    // One command word on the shared bus
    typedef struct packed {
        logic        write;
        logic        spare;
        // Set for RAM, clear for MMIO
        logic        memSpace;
        // Word address; for MMIO the top four bits hold the byte mask
        logic [28:0] addr;
    } MemCmd;

    // One client request, either a cache line or an MMIO word
    typedef struct packed {
        logic        write;
        logic        mmio;
        logic [3:0]  mask;
        logic [29:0] addr;
    } MemReq;

    // Byte address of the serial data register, status follows at +4
    localparam logic [31:0] SERIAL_ADDR = 32'h1000_0000;

    // Byte address bits covered by the MMIO byte mask
    localparam logic [31:0] MMIO_IGNORE_MASK = 32'h7800_0000;

    // Serial status word
    localparam logic [31:0] SERIAL_STATUS_BASE = 32'h0000_6000;
    localparam logic [31:0] SERIAL_RX_READY = 32'h0000_0100;

endpackage

`default_nettype wire

// ==== extMem/SerialStub.sv ====
/* 8250-style serial stub with one receive byte, status and transmit strobe */

`timescale 1ns/1ns
`default_nettype none

module SerialStub import MemBusPkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire         rxValid,
    input  wire  [7:0]  rxByte,
    input  wire         rdData,
    input  wire         rdStatus,
    input  wire         wrData,
    input  wire  [7:0]  wrByte,
    output logic [31:0] rdValue,
    output logic        txValid,
    output logic [7:0]  txByte
);

    logic       rxAvail;
    logic [7:0] rxHold;

    // A fresh byte wins over a read in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            rxAvail <= 1'b0;
        end else if (rxValid) begin
            rxAvail <= 1'b1;
        end else if (rdData) begin
            rxAvail <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rxValid) begin
            rxHold <= rxByte;
        end
    end

    assign rdValue = rdStatus ? (SERIAL_STATUS_BASE | (rxAvail ? SERIAL_RX_READY : 32'h0))
                              : {24'h0, rxAvail ? rxHold : 8'h0};

    // Transmit goes out in the bus data cycle, 7-bit characters only
    assign txValid = wrData;
    assign txByte = {1'b0, wrByte[6:0]};

endmodule

`default_nettype wire

// ==== extMem/ExternalMemorySim.sv ====
/* External memory model: command decode, line bursts on a word RAM,
   MMIO routing to the serial stub */

`timescale 1ns/1ns
`default_nettype none

module ExternalMemorySim import MemBusPkg::*; #(
    parameter int memWords = 65536,
    parameter int clsizeE = 4
) (
    input  wire         clk,
    input  wire         rst,
    input  wire         busEn,
    input  wire  [31:0] ctrlToMem,
    output logic [31:0] memToCtrl,
    output logic        memOen,
    output logic        memStall,
    output logic        txValid,
    output logic [7:0]  txByte,
    input  wire         rxValid,
    input  wire  [7:0]  rxByte
);

    localparam int offBits = clsizeE - 2;
    localparam int ramBits = $clog2(memWords);

    typedef enum logic [1:0] {stLookup, stWrite, stRead} MemState;

    MemState     state;
    MemCmd       cmdIn;
    logic [28:0] curAddr;
    logic        curMem;
    logic [offBits-1:0] lineOff;
    logic [28:0] nextAddr;
    logic [31:0] ram [memWords];
    logic        mmioRead;
    logic        hitData;
    logic        hitStatus;
    logic        serialWrite;
    logic [31:0] serialValue;

    // Register match with the byte-mask bits left out of the compare
    function automatic logic mmioMatch(logic space, logic [28:0] addr,
                                       logic [3:0] wantMask, logic [31:0] regAddr);
        logic [31:0] byteAddr;
        byteAddr = {space, addr, 2'b00};
        return (addr[28:25] == wantMask) &&
               ((byteAddr & ~MMIO_IGNORE_MASK) == (regAddr & ~MMIO_IGNORE_MASK));
    endfunction

    assign cmdIn = MemCmd'(ctrlToMem);

    // Burst address wraps inside the line
    assign lineOff = curAddr[offBits-1:0] + 1'b1;
    assign nextAddr = {curAddr[28:offBits], lineOff};

    assign mmioRead = (state == stLookup) && busEn && !cmdIn.write && !cmdIn.memSpace;
    assign hitData = mmioRead && mmioMatch(cmdIn.memSpace, cmdIn.addr, 4'b0001, SERIAL_ADDR);
    assign hitStatus = mmioRead &&
                       mmioMatch(cmdIn.memSpace, cmdIn.addr, 4'b0010, SERIAL_ADDR + 32'd4);
    assign serialWrite = (state == stWrite) && busEn && !curMem &&
                         mmioMatch(curMem, curAddr, 4'b0001, SERIAL_ADDR);

    SerialStub i_SerialStub (
        .clk(clk),
        .rst(rst),
        .rxValid(rxValid),
        .rxByte(rxByte),
        .rdData(hitData),
        .rdStatus(hitStatus),
        .wrData(serialWrite),
        .wrByte(ctrlToMem[7:0]),
        .rdValue(serialValue),
        .txValid(txValid),
        .txByte(txByte)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stLookup;
            memOen <= 1'b0;
            memStall <= 1'b0;
        end else begin
            memStall <= 1'b0;
            case (state)
                stLookup: begin
                    memOen <= 1'b0;
                    if (busEn) begin
                        if (cmdIn.write) begin
                            state <= stWrite;
                        end else if (cmdIn.memSpace) begin
                            // One stall cycle ahead of the first RAM word
                            memStall <= 1'b1;
                            memOen <= 1'b1;
                            state <= stRead;
                        end else begin
                            memOen <= 1'b1;
                        end
                    end
                end
                stWrite: begin
                    if (!busEn) begin
                        state <= stLookup;
                    end
                end
                stRead: begin
                    memOen <= busEn;
                    if (!busEn) begin
                        state <= stLookup;
                    end
                end
                default: state <= stLookup;
            endcase
        end
    end

    // RAM, burst address and read data
    always_ff @(posedge clk) begin
        if (state == stLookup && busEn) begin
            curAddr <= cmdIn.addr;
            curMem <= cmdIn.memSpace;
            memToCtrl <= (hitData || hitStatus) ? serialValue : 32'h0;
        end
        if (state == stWrite && busEn && curMem) begin
            ram[curAddr[ramBits-1:0]] <= ctrlToMem;
            curAddr <= nextAddr;
        end
        if (state == stRead && busEn) begin
            memToCtrl <= ram[curAddr[ramBits-1:0]];
            curAddr <= nextAddr;
        end
    end

endmodule

`default_nettype wire

// ==== memCtrl/MemoryController.sv ====
/* Memory port controller: line and MMIO requests to bus commands and
   bursts, read data gathered back into a line */

`timescale 1ns/1ns
`default_nettype none

module MemoryController import MemBusPkg::*; #(
    parameter int clsizeE = 4
) (
    input  wire         clk,
    input  wire         rst,
    input  wire         reqValid,
    input  wire MemReq  req,
    input  wire  [(32 << (clsizeE - 2)) - 1:0] wrLine,
    output logic        busy,
    output logic        done,
    output logic [(32 << (clsizeE - 2)) - 1:0] rdLine,
    output logic        busEn,
    output logic [31:0] ctrlToMem,
    input  wire  [31:0] memToCtrl,
    input  wire         memOen
);

    localparam int offBits = clsizeE - 2;
    localparam int lineWords = 1 << offBits;

    typedef enum logic [1:0] {stIdle, stCmd, stData, stFinish} CtrlState;

    CtrlState state;
    logic     opWrite;
    logic     opMmio;
    logic     skipStall;
    logic     capture;
    logic [offBits-1:0] wordCnt;
    logic [offBits-1:0] nextCnt;
    logic [offBits-1:0] rdIdx;
    logic [32*lineWords-1:0] wrReg;
    MemCmd    cmdWord;

    assign nextCnt = wordCnt + 1'b1;

    // Any memOen during a read belongs to this request
    assign capture = memOen && (state != stIdle) && !opWrite;

    always_comb begin
        cmdWord.write = req.write;
        cmdWord.spare = 1'b0;
        cmdWord.memSpace = !req.mmio;
        // MMIO commands carry the byte mask in the top address bits
        if (req.mmio) begin
            cmdWord.addr = {req.mask, req.addr[24:0]};
        end else begin
            cmdWord.addr = req.addr[28:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stIdle;
            busEn <= 1'b0;
            busy <= 1'b0;
            done <= 1'b0;
            opWrite <= 1'b0;
            opMmio <= 1'b0;
            skipStall <= 1'b0;
            wordCnt <= '0;
            rdIdx <= '0;
        end else begin
            done <= 1'b0;
            if (capture) begin
                if (skipStall) begin
                    skipStall <= 1'b0;
                end else begin
                    rdIdx <= rdIdx + 1'b1;
                end
            end
            case (state)
                stIdle: begin
                    if (reqValid) begin
                        opWrite <= req.write;
                        opMmio <= req.mmio;
                        // Line reads see one stall cycle first
                        skipStall <= !req.write && !req.mmio;
                        rdIdx <= '0;
                        busy <= 1'b1;
                        busEn <= 1'b1;
                        state <= stCmd;
                    end
                end
                stCmd: begin
                    wordCnt <= '0;
                    if (opMmio) begin
                        // MMIO write keeps the bus for its single data word
                        busEn <= opWrite;
                        state <= stFinish;
                    end else begin
                        state <= stData;
                    end
                end
                stData: begin
                    if (&wordCnt) begin
                        busEn <= 1'b0;
                        state <= stFinish;
                    end else begin
                        wordCnt <= nextCnt;
                    end
                end
                stFinish: begin
                    busEn <= 1'b0;
                    busy <= 1'b0;
                    done <= 1'b1;
                    state <= stIdle;
                end
                default: state <= stIdle;
            endcase
        end
    end

    // Bus data out and line gathering
    always_ff @(posedge clk) begin
        case (state)
            stIdle: begin
                if (reqValid) begin
                    wrReg <= wrLine;
                    ctrlToMem <= cmdWord;
                end
            end
            stCmd: ctrlToMem <= wrReg[31:0];
            stData: ctrlToMem <= wrReg[32*nextCnt +: 32];
            default: ;
        endcase
        if (capture && !skipStall) begin
            rdLine[32*rdIdx +: 32] <= memToCtrl;
        end
    end

endmodule

`default_nettype wire

// ==== src/MemorySubsystem.sv ====
/* Memory subsystem top: controller and external memory model on one bus */

`timescale 1ns/1ns
`default_nettype none

module MemorySubsystem import MemBusPkg::*; #(
    parameter int memWords = 65536,
    parameter int clsizeE = 4
) (
    input  wire         clk,
    input  wire         rst,
    input  wire         reqValid,
    input  wire MemReq  req,
    input  wire  [(32 << (clsizeE - 2)) - 1:0] wrLine,
    output logic        busy,
    output logic        done,
    output logic [(32 << (clsizeE - 2)) - 1:0] rdLine,
    input  wire         rxValid,
    input  wire  [7:0]  rxByte,
    output logic        txValid,
    output logic [7:0]  txByte
);

    logic        busEn;
    logic [31:0] ctrlToMem;
    logic [31:0] memToCtrl;
    logic        memOen;

    MemoryController #(.clsizeE(clsizeE)) i_MemoryController (
        .clk(clk), .rst(rst), .reqValid(reqValid), .req(req), .wrLine(wrLine),
        .busy(busy), .done(done), .rdLine(rdLine), .busEn(busEn),
        .ctrlToMem(ctrlToMem), .memToCtrl(memToCtrl), .memOen(memOen)
    );

    // Stall pulse is not needed, the controller knows the read latency
    ExternalMemorySim #(.memWords(memWords), .clsizeE(clsizeE)) i_ExternalMemorySim (
        .clk(clk), .rst(rst), .busEn(busEn), .ctrlToMem(ctrlToMem),
        .memToCtrl(memToCtrl), .memOen(memOen), .memStall(),
        .txValid(txValid), .txByte(txByte), .rxValid(rxValid), .rxByte(rxByte)
    );

endmodule

`default_nettype wire

// ==== tests/MemoryChecker.sv ====
/* Response checker comparing done, busy, read line and serial transmit
   with the current expectation record */

`timescale 1ns/1ns
`default_nettype none

module MemoryChecker (
    input  wire          clk,
    input  wire          rst,
    input  wire          reqValid,
    input  wire          busy,
    input  wire          done,
    input  wire  [127:0] rdLine,
    input  wire          txValid,
    input  wire  [7:0]   txByte,
    input  wire  [244:0] expRec,
    output int           valueErrors,
    output int           protocolErrors
);

    // Same layout as the record built in the testbench
    typedef struct packed {
        logic [95:0]  name;
        logic [7:0]   step;
        logic         pending;
        logic [2:0]   rdWords;
        logic [127:0] line;
        logic         txWanted;
        logic [7:0]   txChar;
    } Expect;

    Expect e;
    int    txCount;
    logic  inFlight;

    assign e = expRec;

    // Sampled on the falling edge between DUT updates
    always @(negedge clk) begin
        if (rst) begin
            valueErrors = 0;
            protocolErrors = 0;
            txCount = 0;
            inFlight = 1'b0;
        end else begin
            // Busy from the cycle after the request up to done
            if (busy !== (inFlight && !done)) begin
                $display("[FAIL] %s step %0d busy expected %0b actual %0b",
                         e.name, e.step, inFlight && !done, busy);
                valueErrors++;
            end
            if (txValid) begin
                if (!e.txWanted) begin
                    $display("Unexpected transmit of 0x%02h during step %0d", txByte, e.step);
                    protocolErrors++;
                end else begin
                    txCount++;
                    if (txByte !== e.txChar) begin
                        $display("[FAIL] %s step %0d txByte expected 0x%02h actual 0x%02h",
                                 e.name, e.step, e.txChar, txByte);
                        valueErrors++;
                    end
                end
            end
            if (done) begin
                if (!e.pending) begin
                    $display("Done pulse seen with no request pending (step %0d)", e.step);
                    protocolErrors++;
                end else begin
                    for (int i = 0; i < e.rdWords; i++) begin
                        if (rdLine[32*i +: 32] !== e.line[32*i +: 32]) begin
                            $display("[FAIL] %s step %0d word %0d expected 0x%08h actual 0x%08h",
                                     e.name, e.step, i, e.line[32*i +: 32],
                                     rdLine[32*i +: 32]);
                            valueErrors++;
                        end
                    end
                    if (e.txWanted && txCount != 1) begin
                        $display("Step %0d expected one transmit but saw %0d", e.step, txCount);
                        protocolErrors++;
                    end
                end
                txCount = 0;
                inFlight = 1'b0;
            end
            if (reqValid) begin
                inFlight = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/MemorySubsystem_tb.sv ====
/* Memory subsystem testbench with clock, reset, trace driven requests,
   serial input and cycle limit */

`timescale 1ns/1ns
`default_nettype none

module MemorySubsystem_tb import MemBusPkg::*; ();

    localparam int lineWords = 4;
    localparam int maxOps = 64;
    localparam int resetCycles = 16;

    typedef struct packed {
        logic [95:0]  name;
        logic [7:0]   step;
        logic         pending;
        logic [2:0]   rdWords;
        logic [127:0] line;
        logic         txWanted;
        logic [7:0]   txChar;
    } Expect;

    logic         clk;
    logic         rst;
    logic         reqValid;
    MemReq        req;
    logic [127:0] wrLine;
    logic         busy;
    logic         done;
    logic [127:0] rdLine;
    logic         rxValid;
    logic [7:0]   rxByte;
    logic         txValid;
    logic [7:0]   txByte;
    Expect        expRec;
    int           valueErrors;
    int           protocolErrors;
    int           traceErrors;
    int           cycles;
    int           cycleLimit;
    int           numOps;
    int           seed;
    logic [31:0]  trace [5*maxOps];
    logic [31:0]  model [int];

    MemorySubsystem #(.memWords(65536), .clsizeE(4)) i_MemorySubsystem (
        .clk(clk), .rst(rst), .reqValid(reqValid), .req(req), .wrLine(wrLine),
        .busy(busy), .done(done), .rdLine(rdLine), .rxValid(rxValid),
        .rxByte(rxByte), .txValid(txValid), .txByte(txByte)
    );

    MemoryChecker i_MemoryChecker (
        .clk(clk), .rst(rst), .reqValid(reqValid), .busy(busy), .done(done),
        .rdLine(rdLine), .txValid(txValid), .txByte(txByte), .expRec(expRec),
        .valueErrors(valueErrors), .protocolErrors(protocolErrors)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            $display("Run stopped after %0d cycles, a request never finished", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic logic [95:0] opName(logic [31:0] op);
        case (op)
            1: return "line write";
            2: return "line read";
            3: return "mmio write";
            4: return "mmio read";
            default: return "serial rx";
        endcase
    endfunction

    // Drive one trace line and wait for done where a request goes out
    task automatic runStep(int n);
        logic [31:0]  op;
        logic [31:0]  addr;
        logic [31:0]  data;
        logic [31:0]  want;
        MemReq        r;
        logic [127:0] line;
        Expect        e;
        int           base;
        int           off;
        op = trace[5*n];
        addr = trace[5*n+1];
        data = trace[5*n+3];
        want = trace[5*n+4];
        @(posedge clk);
        #1;
        e = '0;
        e.name = opName(op);
        e.step = n[7:0];
        r = '0;
        line = '0;
        r.addr = addr[31:2];
        r.mask = trace[5*n+2][3:0];
        off = int'(addr[3:2]);
        base = int'(addr[31:2]) - off;
        case (op)
            1: begin
                r.write = 1'b1;
                // Burst wraps inside the line from the start offset
                for (int i = 0; i < lineWords; i++) begin
                    line[32*i +: 32] = $random(seed);
                    model[base + (off + i) % lineWords] = line[32*i +: 32];
                end
            end
            2: begin
                e.rdWords = 3'd4;
                for (int i = 0; i < lineWords; i++) begin
                    e.line[32*i +: 32] = model.exists(base + i) ? model[base + i] : 32'h0;
                end
            end
            3: begin
                r.write = 1'b1;
                r.mmio = 1'b1;
                line[31:0] = data;
                e.txWanted = (want != 32'hFFFF_FFFF);
                e.txChar = want[7:0];
            end
            4: begin
                r.mmio = 1'b1;
                e.rdWords = 3'd1;
                e.line[31:0] = want;
            end
            5: begin
                rxValid = 1'b1;
                rxByte = data[7:0];
            end
            default: begin
                $display("Trace line %0d has an unknown operation %0d", n, op);
                traceErrors++;
            end
        endcase
        e.pending = (op >= 1 && op <= 4);
        expRec = e;
        if (e.pending) begin
            req = r;
            wrLine = line;
            reqValid = 1'b1;
        end
        @(posedge clk);
        #1;
        reqValid = 1'b0;
        rxValid = 1'b0;
        if (e.pending) begin
            do @(negedge clk); while (!done);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        reqValid = 1'b0;
        req = '0;
        wrLine = '0;
        rxValid = 1'b0;
        rxByte = 8'h0;
        expRec = '0;
        seed = 43100;
        cycles = 0;
        traceErrors = 0;
        for (int k = 0; k < 5*maxOps; k++) begin
            trace[k] = 32'h0;
        end
        $readmemh("tests/memTrace.txt", trace);
        numOps = 0;
        while (numOps < maxOps && trace[5*numOps] != 0) begin
            numOps++;
        end
        cycleLimit = resetCycles + 40 * numOps;
        repeat (resetCycles) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int n = 0; n < numOps; n++) begin
            runStep(n);
        end
        @(posedge clk);
        #1;
        expRec = '0;
        repeat (4) @(negedge clk);
        $display("Errors: %0d value, %0d protocol, %0d trace",
                 valueErrors, protocolErrors, traceErrors);
        if (valueErrors == 0 && protocolErrors == 0 && traceErrors == 0 && numOps > 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/memTrace.txt ====
// op byteAddr mask data expected, all hex; op 1 line wr, 2 line rd, 3 mmio wr,
// 4 mmio rd, 5 serial rx, 0 ends; mmio wr expected FFFFFFFF means no transmit
1 00000100 0 00000000 00000000  // aligned line write, random data
2 00000100 0 00000000 00000000  // read back
1 00000208 0 00000000 00000000  // start at offset 2, wraps
2 00000200 0 00000000 00000000  // rotated line
3 10000000 1 000000C1 00000041  // transmit, top bit dropped
3 10000000 1 0000005A 0000005A
4 10000004 2 00000000 00006000  // status, nothing waiting
5 00000000 0 00000037 00000000  // receive a byte
4 10000004 2 00000000 00006100
4 10000000 1 00000000 00000037
4 10000004 2 00000000 00006000
4 10000000 1 00000000 00000000  // second data read is empty
4 10000008 1 00000000 00000000  // unknown register
4 10000000 4 00000000 00000000  // wrong mask
4 00000100 1 00000000 00000000
3 10000004 1 00000033 FFFFFFFF  // status write does nothing
3 10000000 2 00000033 FFFFFFFF
3 00000100 1 12345678 FFFFFFFF  // must not touch the line at 0x100
2 00000100 0 00000000 00000000
0 00000000 0 00000000 00000000

// ==== MemorySubsystem.f ====
common/MemBusPkg.sv
extMem/SerialStub.sv
extMem/ExternalMemorySim.sv
memCtrl/MemoryController.sv
src/MemorySubsystem.sv
tests/MemoryChecker.sv
tests/MemorySubsystem_tb.sv

// ==== Makefile ====
# Verilator build and run for the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= MemorySubsystem_tb
FILELIST  ?= MemorySubsystem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "STATUS: PASS" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
